// File: hw/median_cfg.svh
`ifndef MEDIAN_CFG_SVH
`define MEDIAN_CFG_SVH

// image format of the filter

// bits per grayscale pixel
`define MF_PIXEL_WIDTH 8

// pixels per row, any value of 3 or more
`define MF_LINE_WIDTH 16

`endif

// File: hw/median_pkg.sv
`default_nettype none

`include "median_cfg.svh"

package median_pkg;

    localparam int COL_W = $clog2(`MF_LINE_WIDTH);   // column index width

    typedef logic [`MF_PIXEL_WIDTH-1:0] pixel_t;
    typedef logic [COL_W-1:0]           col_idx_t;

    typedef struct packed {
        logic   valid;
        logic   sof;      // first pixel of a frame
        pixel_t data;
    } pix_stream_t;

    typedef struct packed {
        logic   valid;
        logic   win_ok;   // full 3x3 window ends here
        pixel_t top;      // two rows up
        pixel_t mid;      // one row up
        pixel_t bot;      // current row
    } pix_col_t;

    // one window column, ordered top >= mid >= bot once sorted
    typedef struct packed {
        pixel_t top;
        pixel_t mid;
        pixel_t bot;
    } pix_set_t;

    typedef struct packed {
        pix_set_t c1;     // oldest column
        pix_set_t c2;
        pix_set_t c3;     // newest column
    } pix_win_t;

    typedef struct packed {
        logic   valid;
        pixel_t data;
    } median_out_t;

    typedef enum logic [1:0] {FILL_ROW0, FILL_ROW1, STREAM} fill_state_e;

    typedef enum logic [1:0] {NODE_LO, NODE_HI, NODE_BOTH} node_mode_e;

endpackage

`default_nettype wire

// File: hw/sort_node.sv
`timescale 1ns/1ps
`default_nettype none

module sort_node #(
    parameter median_pkg::node_mode_e mode = median_pkg::NODE_BOTH
) (
    input  wire median_pkg::pixel_t data_a,
    input  wire median_pkg::pixel_t data_b,
    output median_pkg::pixel_t      data_hi,
    output median_pkg::pixel_t      data_lo
);
    import median_pkg::*;

    logic   a_lt_b;
    pixel_t min_v;
    pixel_t max_v;

    assign a_lt_b = data_a < data_b;
    assign min_v  = a_lt_b ? data_a : data_b;   // ties go to data_b
    assign max_v  = a_lt_b ? data_b : data_a;

    // unselected side is tied low
    assign data_lo = (mode == NODE_HI) ? '0 : min_v;
    assign data_hi = (mode == NODE_LO) ? '0 : max_v;

endmodule

`default_nettype wire

// File: hw/median_network.sv
`timescale 1ns/1ps
`default_nettype none

// Expects every column already sorted (top >= mid >= bot). The median is then
// the median of min(tops), median(mids) and max(bots).
module median_network (
    input  wire median_pkg::pix_win_t win,
    output median_pkg::pixel_t        median
);
    import median_pkg::*;

    pixel_t node_u0_lo;
    pixel_t node_u1_hi;
    pixel_t node_u1_lo;
    pixel_t node_u2_hi;
    pixel_t node_u3_lo;
    pixel_t node_u4_hi;
    pixel_t node_u5_hi;
    pixel_t node_u6_lo;
    pixel_t node_u7_hi;
    pixel_t node_u7_lo;
    pixel_t node_u8_hi;

    sort_node #(.mode(NODE_LO)) node_u0 (   // tops of c3, c2
        .data_a  (win.c3.top),
        .data_b  (win.c2.top),
        .data_hi (),
        .data_lo (node_u0_lo)
    );

    sort_node #(.mode(NODE_BOTH)) node_u1 (   // mids of c3, c2
        .data_a  (win.c3.mid),
        .data_b  (win.c2.mid),
        .data_hi (node_u1_hi),
        .data_lo (node_u1_lo)
    );

    sort_node #(.mode(NODE_HI)) node_u2 (   // bots of c2, c1
        .data_a  (win.c2.bot),
        .data_b  (win.c1.bot),
        .data_hi (node_u2_hi),
        .data_lo ()
    );

    sort_node #(.mode(NODE_LO)) node_u3 (   // min of all tops
        .data_a  (node_u0_lo),
        .data_b  (win.c1.top),
        .data_hi (),
        .data_lo (node_u3_lo)
    );

    sort_node #(.mode(NODE_HI)) node_u4 (
        .data_a  (node_u1_lo),
        .data_b  (win.c1.mid),
        .data_hi (node_u4_hi),
        .data_lo ()
    );

    sort_node #(.mode(NODE_HI)) node_u5 (   // max of all bots
        .data_a  (win.c3.bot),
        .data_b  (node_u2_hi),
        .data_hi (node_u5_hi),
        .data_lo ()
    );

    sort_node #(.mode(NODE_LO)) node_u6 (   // median of the mids
        .data_a  (node_u1_hi),
        .data_b  (node_u4_hi),
        .data_hi (),
        .data_lo (node_u6_lo)
    );

    // last three nodes take the median of the three candidates
    sort_node #(.mode(NODE_BOTH)) node_u7 (
        .data_a  (node_u3_lo),
        .data_b  (node_u6_lo),
        .data_hi (node_u7_hi),
        .data_lo (node_u7_lo)
    );

    sort_node #(.mode(NODE_HI)) node_u8 (
        .data_a  (node_u7_lo),
        .data_b  (node_u5_hi),
        .data_hi (node_u8_hi),
        .data_lo ()
    );

    sort_node #(.mode(NODE_LO)) node_u9 (
        .data_a  (node_u7_hi),
        .data_b  (node_u8_hi),
        .data_hi (),
        .data_lo (median)
    );

endmodule

`default_nettype wire

// File: hw/line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "median_cfg.svh"

module line_buffer (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 wr_en,
    input  wire median_pkg::col_idx_t addr,
    input  wire median_pkg::pixel_t   wr_data,
    output median_pkg::pixel_t        row1,
    output median_pkg::pixel_t        row2
);
    import median_pkg::*;

    pixel_t mem_row1 [`MF_LINE_WIDTH];   // one row above
    pixel_t mem_row2 [`MF_LINE_WIDTH];   // two rows above

    // read before the write lands at this edge
    assign row1 = mem_row1[addr];
    assign row2 = mem_row2[addr];

    always_ff @(posedge clk)
    begin
        if (wr_en && !rst)   // contents frozen during reset
        begin
            mem_row2[addr] <= mem_row1[addr];   // both rows age together
            mem_row1[addr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// File: hw/window_generator.sv
`timescale 1ns/1ps
`default_nettype none

`include "median_cfg.svh"

module window_generator (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire median_pkg::pix_stream_t pix_in,
    output logic                         lb_wr_en,
    output median_pkg::col_idx_t         lb_addr,
    output median_pkg::pixel_t           lb_wr_data,
    input  wire median_pkg::pixel_t      lb_row1,
    input  wire median_pkg::pixel_t      lb_row2,
    output median_pkg::pix_col_t         col
);
    import median_pkg::*;

    localparam col_idx_t LAST_COL = col_idx_t'(`MF_LINE_WIDTH - 1);

    fill_state_e state_q;         // doubles as the row position
    fill_state_e cur_state;
    fill_state_e row_end_state;
    col_idx_t    col_q;
    col_idx_t    cur_col;

    // sof puts this very pixel at row 0, column 0
    assign cur_state = pix_in.sof ? FILL_ROW0 : state_q;
    assign cur_col   = pix_in.sof ? '0 : col_q;

    always_comb
    begin
        case (cur_state)
            FILL_ROW0: row_end_state = FILL_ROW1;
            default:   row_end_state = STREAM;   // stays here until next sof
        endcase
    end

    assign lb_wr_en   = pix_in.valid;
    assign lb_addr    = cur_col;
    assign lb_wr_data = pix_in.data;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q <= FILL_ROW0;
            col_q   <= '0;
        end
        else if (pix_in.valid)
        begin
            if (cur_col == LAST_COL)
            begin
                col_q   <= '0;
                state_q <= row_end_state;
            end
            else
            begin
                col_q   <= cur_col + 1'b1;
                state_q <= cur_state;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            col.valid  <= 1'b0;
            col.win_ok <= 1'b0;
        end
        else
        begin
            col.valid  <= pix_in.valid;
            col.win_ok <= pix_in.valid && (cur_state == STREAM) && (cur_col >= col_idx_t'(2));
        end
        col.top <= lb_row2;
        col.mid <= lb_row1;
        col.bot <= pix_in.data;
    end

endmodule

`default_nettype wire

// File: hw/median_stage.sv
`timescale 1ns/1ps
`default_nettype none

module median_stage (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire median_pkg::pix_col_t col,
    output median_pkg::median_out_t   med_out
);
    import median_pkg::*;

    pix_set_t col_sorted;
    pix_win_t win_q;
    logic     win_ok_q;
    pixel_t   median;

    // orders a column so the network sees top >= mid >= bot
    function automatic pix_set_t sort3(input pixel_t a, input pixel_t b, input pixel_t c);
        pixel_t   lo_ab;
        pixel_t   hi_ab;
        pix_set_t s;
        lo_ab = (a < b) ? a : b;
        hi_ab = (a < b) ? b : a;
        if (c >= hi_ab)
        begin
            s = '{top: c, mid: hi_ab, bot: lo_ab};
        end
        else if (c >= lo_ab)
        begin
            s = '{top: hi_ab, mid: c, bot: lo_ab};
        end
        else
        begin
            s = '{top: hi_ab, mid: lo_ab, bot: c};
        end
        return s;
    endfunction

    assign col_sorted = sort3(col.top, col.mid, col.bot);   // sorted once on entry

    always_ff @(posedge clk)
    begin
        if (col.valid)
        begin
            win_q.c1 <= win_q.c2;
            win_q.c2 <= win_q.c3;
            win_q.c3 <= col_sorted;
        end
    end

    median_network u_network (
        .win    (win_q),
        .median (median)
    );

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            win_ok_q      <= 1'b0;
            med_out.valid <= 1'b0;
        end
        else
        begin
            win_ok_q      <= col.valid && col.win_ok;
            med_out.valid <= win_ok_q;
        end
        med_out.data <= median;
    end

endmodule

`default_nettype wire

// File: hw/median_filter_top.sv
`timescale 1ns/1ps
`default_nettype none

module median_filter_top (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire median_pkg::pix_stream_t pix_in,
    output median_pkg::median_out_t      med_out
);
    import median_pkg::*;

    logic     lb_wr_en;
    col_idx_t lb_addr;
    pixel_t   lb_wr_data;
    pixel_t   lb_row1;
    pixel_t   lb_row2;
    pix_col_t col;     // producer to consumer

    window_generator u_window_gen (
        .clk        (clk),
        .rst        (rst),
        .pix_in     (pix_in),
        .lb_wr_en   (lb_wr_en),
        .lb_addr    (lb_addr),
        .lb_wr_data (lb_wr_data),
        .lb_row1    (lb_row1),
        .lb_row2    (lb_row2),
        .col        (col)
    );

    line_buffer u_line_buffer (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (lb_wr_en),
        .addr    (lb_addr),
        .wr_data (lb_wr_data),
        .row1    (lb_row1),
        .row2    (lb_row2)
    );

    median_stage u_median_stage (
        .clk     (clk),
        .rst     (rst),
        .col     (col),
        .med_out (med_out)
    );

endmodule

`default_nettype wire

// File: verification/median_ref_model.svh
`ifndef MEDIAN_REF_MODEL_SVH
`define MEDIAN_REF_MODEL_SVH

// frame model, included inside the testbench module
// keeps the last three rows and gives the median of every interior 3x3 window

pixel_t model_img [3][`MF_LINE_WIDTH];   // row r lives at r % 3
int     model_row;
int     model_col;

task automatic model_start_frame();
    model_row = 0;
    model_col = 0;
endtask

// sort all nine, fifth one is the median
function automatic pixel_t model_median9(input pixel_t v [9]);
    pixel_t s [9];
    pixel_t t;
    s = v;
    for (int i = 0; i < 8; i++)
    begin
        for (int k = 0; k < 8 - i; k++)
        begin
            if (s[k] > s[k + 1])
            begin
                t        = s[k];
                s[k]     = s[k + 1];
                s[k + 1] = t;
            end
        end
    end
    return s[4];
endfunction

// stores one pixel, has_win set when it closes an interior window
task automatic model_push(input pixel_t p, output bit has_win, output pixel_t med);
    pixel_t v [9];
    model_img[model_row % 3][model_col] = p;
    has_win = (model_row >= 2) && (model_col >= 2);
    med     = '0;
    if (has_win)
    begin
        for (int dr = 0; dr < 3; dr++)
        begin
            for (int dc = 0; dc < 3; dc++)
            begin
                v[dr * 3 + dc] = model_img[(model_row - dr) % 3][model_col - dc];
            end
        end
        med = model_median9(v);
    end
    if (model_col == `MF_LINE_WIDTH - 1)
    begin
        model_col = 0;
        model_row++;
    end
    else
    begin
        model_col++;
    end
endtask

`endif

// File: verification/median_filter_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "median_cfg.svh"

module median_filter_tb;
    import median_pkg::*;

    `include "median_ref_model.svh"

    localparam int W           = `MF_LINE_WIDTH;
    localparam int TOTAL_PIX   = 97 * W + 17;                          // all frames below
    localparam int WATCHDOG_NS = (4 * TOTAL_PIX + 6 * 80 + 20) * 4;    // up to 3 idle per pixel
    localparam int PAT_RANDOM  = 0;
    localparam int PAT_CONST   = 1;
    localparam int PAT_EXTREME = 2;   // only 0 and all ones
    localparam int PAT_TIES    = 3;   // two neighboring values

    logic        clk;
    logic        rst;
    pix_stream_t pix_in;
    median_out_t med_out;
    int          cyc = 0;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    int          res_count;
    int          exp_count;
    int          exp_cyc;
    int          pix_since_rst;
    string       test_name;
    pixel_t      exp_data_q [$];
    int          exp_cyc_q [$];   // cycle each result is due

    median_filter_top i_dut (
        .clk     (clk),
        .rst     (rst),
        .pix_in  (pix_in),
        .med_out (med_out)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cyc <= cyc + 1;
    end

    task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
        if (exp !== act)
        begin
            $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act)
        begin
            $display("mismatch %s result count: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    function automatic pixel_t gen_pixel(input int pat, input pixel_t base);
        case (pat)
            PAT_CONST:   return base;
            PAT_EXTREME: return ($urandom_range(1) != 0) ? ~pixel_t'(0) : pixel_t'(0);
            PAT_TIES:    return base + pixel_t'($urandom_range(1));
            default:     return pixel_t'($urandom);
        endcase
    endfunction

    task automatic idle_cycle();
        @(posedge clk);
        #1;
        pix_in = '{valid: 1'b0, sof: 1'b0, data: pixel_t'($urandom)};   // data must be ignored
    endtask

    task automatic send_pixel(input pixel_t p, input logic sof, input int gap_pct);
        bit     has_win;
        pixel_t med;
        if ($urandom_range(99) < gap_pct)
        begin
            repeat ($urandom_range(3, 1)) idle_cycle();
        end
        @(posedge clk);
        #1;
        pix_in = '{valid: 1'b1, sof: sof, data: p};
        pix_since_rst++;
        model_push(p, has_win, med);
        if (has_win)
        begin
            exp_data_q.push_back(med);
            exp_cyc_q.push_back(cyc + 3);   // accepted next edge, out two edges later
        end
    endtask

    // n_pix pixels, sof on the first one unless with_sof is clear
    task automatic run_frame(input int n_pix, input int pat, input int gap_pct,
                             input bit with_sof = 1'b1);
        pixel_t base;
        int     rows;
        int     rem;
        base = pixel_t'($urandom);
        rows = n_pix / W;
        rem  = n_pix % W;
        model_start_frame();
        for (int i = 0; i < n_pix; i++)
        begin
            send_pixel(gen_pixel(pat, base), with_sof && (i == 0), gap_pct);
        end
        if (rows >= 2)   // full interior rows plus the cut last row
        begin
            exp_count += (rows - 2) * (W - 2) + ((rem > 2) ? rem - 2 : 0);
        end
    endtask

    // results due after the reset edge never come out
    task automatic apply_reset();
        @(posedge clk);
        #1;
        rst    = 1'b1;
        pix_in = '{valid: 1'b0, sof: 1'b0, data: '0};
        while (exp_cyc_q.size() != 0 && exp_cyc_q[$] > cyc)
        begin
            void'(exp_cyc_q.pop_back());
            void'(exp_data_q.pop_back());
            exp_count--;
        end
        repeat (5) @(posedge clk);
        #1;
        pix_since_rst = 0;
        rst           = 1'b0;
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = errors;
        res_count   = 0;
        exp_count   = 0;
    endtask

    task automatic end_test();
        int waited;
        waited = 0;
        idle_cycle();
        while (exp_data_q.size() != 0 && waited < 64)
        begin
            idle_cycle();
            waited++;
        end
        if (exp_data_q.size() != 0)
        begin
            $display("%s: %0d expected results never appeared", test_name, exp_data_q.size());
            errors++;
            exp_data_q.delete();
            exp_cyc_q.delete();
        end
        repeat (4) idle_cycle();   // room for stray late results
        check_count(test_name, exp_count, res_count);
        tests_run++;
        if (errors != test_errors)
        begin
            tests_failed++;
        end
        $display("test %s: %s, %0d results", test_name,
                 (errors == test_errors) ? "ok" : "FAILED", res_count);
    endtask

    always @(negedge clk)
    begin
        if (med_out.valid === 1'b1)
        begin
            res_count++;
            if (pix_since_rst < 2 * W + 3)
            begin
                $display("%s: result seen before two rows filled after reset", test_name);
                errors++;
            end
            if (exp_data_q.size() == 0)
            begin
                $display("%s: unexpected result %0d with none pending", test_name, med_out.data);
                errors++;
            end
            else
            begin
                exp_cyc = exp_cyc_q.pop_front();
                check_pixel(test_name, exp_data_q.pop_front(), med_out.data);
                if (exp_cyc != cyc)
                begin
                    $display("%s: result came at cycle %0d instead of %0d",
                             test_name, cyc, exp_cyc);
                    errors++;
                end
            end
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("Test failures found");
        $finish;
    end

    initial
    begin
        void'($urandom(90679));
        rst           = 1'b1;
        pix_in        = '{valid: 1'b0, sof: 1'b0, data: '0};
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        pix_since_rst = 0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        begin_test("dense_random");
        run_frame(6 * W, PAT_RANDOM, 0);
        run_frame(8 * W, PAT_RANDOM, 0);
        run_frame(5 * W, PAT_RANDOM, 0);
        end_test();

        begin_test("random_gaps");
        run_frame(6 * W, PAT_RANDOM, 30);
        run_frame(8 * W, PAT_RANDOM, 30);
        run_frame(5 * W, PAT_RANDOM, 30);
        end_test();

        begin_test("result_count");
        run_frame(3 * W, PAT_RANDOM, 10);   // single output row
        run_frame(10 * W, PAT_RANDOM, 10);
        end_test();

        begin_test("special_patterns");
        run_frame(5 * W, PAT_CONST, 0);
        run_frame(6 * W, PAT_TIES, 15);
        run_frame(6 * W, PAT_EXTREME, 15);
        run_frame(4 * W, PAT_CONST, 0);
        end_test();

        begin_test("sof_restart");
        run_frame(3 * W + 5, PAT_RANDOM, 0);   // cut short by the next sof
        run_frame(6 * W, PAT_RANDOM, 0);
        run_frame(W + 3, PAT_RANDOM, 20);
        run_frame(5 * W, PAT_RANDOM, 20);
        end_test();

        begin_test("reset_mid_frame");
        run_frame(4 * W + 9, PAT_RANDOM, 20);
        apply_reset();
        run_frame(6 * W, PAT_RANDOM, 20, 1'b0);   // no sof, row and column start from reset
        end_test();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
        begin
            $display("All tests passed!");
        end
        else
        begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: median_filter.f
+incdir+hw
+incdir+verification
hw/median_pkg.sv
hw/sort_node.sv
hw/median_network.sv
hw/line_buffer.sv
hw/window_generator.sv
hw/median_stage.sv
hw/median_filter_top.sv
verification/median_filter_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the median filter testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module median_filter_tb \
    -f median_filter.f --Mdir obj_dir -o median_filter_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/median_filter_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed!" "$LOG"; then
    exit 0
fi
exit 1
